// File: Bender.yml
package:
  name: snappy_preparser

sources:
  # design, package first
  - files:
      - logic/preparser_pkg.sv
      - logic/tag_decoder.sv
      - logic/slice_builder.sv
      - logic/token_decode_stage.sv
      - logic/token_chain_stage.sv
      - logic/length_accum_stage.sv
      - logic/snappy_preparser.sv

  # testbench, top module preparser_tb
  - target: test
    files:
      - test/clock_gen.sv
      - test/preparser_assert.sv
      - test/preparser_tb.sv

// File: flist.f
logic/preparser_pkg.sv
logic/tag_decoder.sv
logic/slice_builder.sv
logic/token_decode_stage.sv
logic/token_chain_stage.sv
logic/length_accum_stage.sv
logic/snappy_preparser.sv
test/clock_gen.sv
test/preparser_assert.sv
test/preparser_tb.sv

// File: logic/length_accum_stage.sv
/* one cycle, address is the output length of all earlier slices in the stream
   wraps modulo 2^32 */
`timescale 1ns/1ps
`default_nettype none

module length_accum_stage import preparser_pkg::*; (
	input  wire logic      clk,
	input  wire logic      rst_n,
	input  wire pos_mask_t token_pos,
	input  wire logic      start_lit,
	input  wire dlen_arr_t dlens,
	input  wire slice_t    slice,
	input  wire logic      valid,
	input  wire logic      first,
	output slice_t         slice_data,
	output pos_mask_t      token_pos_q,
	output logic           start_lit_q,
	output addr_t          address,
	output logic           slice_valid
);

	addr_t total;                      // running sum after the last slice
	addr_t base;
	addr_t lvl1 [8];
	addr_t lvl2 [4];
	addr_t lvl3 [2];
	addr_t slice_sum;

	//////////////////////////////
	// adder tree over started tokens
	always_comb begin
		for (int k = 0; k < 8; k++) begin
			lvl1[k] = (token_pos[beat_bytes-1-2*k] ? addr_t'(dlens[2*k]) : '0)
				+ (token_pos[beat_bytes-2-2*k] ? addr_t'(dlens[2*k+1]) : '0);
		end
		for (int k = 0; k < 4; k++)
			lvl2[k] = lvl1[2*k] + lvl1[2*k+1];
		for (int k = 0; k < 2; k++)
			lvl3[k] = lvl2[2*k] + lvl2[2*k+1];
		slice_sum = lvl3[0] + lvl3[1];
	end

	assign base = first ? '0 : total;  // new stream starts at zero

	always_ff @(posedge clk) begin
		slice_data  <= slice;
		token_pos_q <= token_pos;
		start_lit_q <= start_lit;
		if (!rst_n) begin
			total       <= '0;
			address     <= '0;
			slice_valid <= 1'b0;
		end else begin
			slice_valid <= valid;
			if (valid) begin
				address <= base;                // earlier slices only
				total   <= base + slice_sum;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/preparser_pkg.sv
/* shared widths, tag codes and byte views of the snappy pre-parser
   four-byte-offset copies and literal length fields 62/63 are not supported */
`default_nettype none

package preparser_pkg;

	//////////////////////////////
	// geometry
	localparam int beat_bytes  = 16;                   // bytes per input beat
	localparam int look_bytes  = 2;                    // lookahead taken from next beat
	localparam int slice_bytes = beat_bytes + look_bytes;
	localparam int addr_w      = 32;                   // decompressed address width

	//////////////////////////////
	// tag encodings
	localparam logic [7:0] lit_ext1_tag = 8'hF0;       // literal, one length byte follows
	localparam logic [7:0] lit_ext2_tag = 8'hF4;       // literal, two length bytes follow

	// low two bits of every tag
	localparam logic [1:0] kind_literal = 2'b00;
	localparam logic [1:0] kind_copy1   = 2'b01;       // one-byte offset copy
	localparam logic [1:0] kind_copy2   = 2'b10;       // two-byte offset copy

	//////////////////////////////
	// data words, byte 0 always in the top bits
	typedef logic [beat_bytes*8-1:0]  beat_t;
	typedef logic [slice_bytes*8-1:0] slice_t;          // 16 bytes then 2 lookahead bytes
	typedef logic [beat_bytes-1:0]    pos_mask_t;       // bit 15 is byte 0
	typedef logic [16:0]              span_t;           // up to 65539 stream bytes
	typedef logic [16:0]              dlen_t;           // up to 65536 output bytes
	typedef logic [addr_w-1:0]        addr_t;

	// literal reading of a tag byte
	typedef struct packed {
		logic [5:0] len;                                // length minus one
		logic [1:0] kind;
	} lit_tag_t;

	// copy reading of a tag byte
	typedef struct packed {
		logic [2:0] off_hi;                             // offset bits 10..8
		logic [2:0] len;                                // length minus four
		logic [1:0] kind;
	} copy1_tag_t;

	// same byte, two readings
	typedef union packed {
		lit_tag_t   lit;
		copy1_tag_t copy;
	} tag_byte_u;

	// per byte position, index j is slice byte j
	typedef span_t [beat_bytes-1:0] span_arr_t;
	typedef dlen_t [beat_bytes-1:0] dlen_arr_t;

endpackage

`default_nettype wire

// File: logic/slice_builder.sv
/* source must leave one idle cycle after beat_last, a beat there is lost
   the final slice of a stream carries zero lookahead */
`timescale 1ns/1ps
`default_nettype none

module slice_builder import preparser_pkg::*; (
	input  wire logic  clk,
	input  wire logic  rst_n,
	input  wire beat_t beat_data,
	input  wire logic  beat_valid,
	input  wire logic  beat_last,
	output slice_t     slice,
	output logic       slice_valid,
	output logic       slice_first
);

	beat_t prev_beat;      // waits for the next beat's head bytes
	logic  has_prev;
	logic  flush;          // tail slice goes out this cycle
	logic  first_pend;     // next emitted slice opens a stream

	// head of the incoming beat becomes lookahead of the held one
	wire logic [look_bytes*8-1:0] look_in = beat_data[beat_bytes*8-1 -: look_bytes*8];

	//////////////////////////////
	// beat holding and slice emit
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			has_prev    <= 1'b0;
			flush       <= 1'b0;
			first_pend  <= 1'b1;
			slice_valid <= 1'b0;
			slice_first <= 1'b0;
		end else begin
			slice_valid <= 1'b0;
			if (flush) begin
				// stream tail, nothing follows it
				slice       <= {prev_beat, {look_bytes*8{1'b0}}};
				slice_valid <= 1'b1;
				slice_first <= first_pend;
				has_prev    <= 1'b0;
				flush       <= 1'b0;
				first_pend  <= 1'b1;            // next stream restarts
			end else if (beat_valid) begin
				if (has_prev) begin
					slice       <= {prev_beat, look_in};
					slice_valid <= 1'b1;
					slice_first <= first_pend;
					first_pend  <= 1'b0;
				end
				prev_beat <= beat_data;
				has_prev  <= 1'b1;
				flush     <= beat_last;         // one-beat stream flushes too
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/snappy_preparser.sv
/* snappy block pre-parser, one 16-byte beat per cycle, no back-pressure
   slice k leaves four cycles after beat k+1, idle cycle needed after beat_last */
`timescale 1ns/1ps
`default_nettype none

module snappy_preparser import preparser_pkg::*; (
	input  wire logic  clk,
	input  wire logic  rst_n,
	input  wire beat_t beat_data,
	input  wire logic  beat_valid,
	input  wire logic  beat_last,
	output slice_t     slice_data,
	output pos_mask_t  token_pos,
	output logic       start_lit,
	output addr_t      address,
	output logic       slice_valid
);

	// builder -> decode
	slice_t    bld_slice;
	logic      bld_valid;
	logic      bld_first;

	// decode -> chain
	span_arr_t dec_spans;
	dlen_arr_t dec_dlens;
	pos_mask_t dec_lit;
	slice_t    dec_slice;
	logic      dec_valid;
	logic      dec_first;

	// chain -> accumulate
	pos_mask_t chn_pos;
	logic      chn_start_lit;
	dlen_arr_t chn_dlens;
	slice_t    chn_slice;
	logic      chn_valid;
	logic      chn_first;

	//////////////////////////////
	slice_builder u_builder (
		.clk, .rst_n, .beat_data, .beat_valid, .beat_last,
		.slice       (bld_slice),
		.slice_valid (bld_valid),
		.slice_first (bld_first)
	);

	token_decode_stage u_decode (
		.clk, .rst_n,
		.slice       (bld_slice),
		.slice_valid (bld_valid),
		.slice_first (bld_first),
		.spans       (dec_spans),
		.dlens       (dec_dlens),
		.lit_marks   (dec_lit),
		.slice_q     (dec_slice),
		.valid_q     (dec_valid),
		.first_q     (dec_first)
	);

	token_chain_stage u_chain (
		.clk, .rst_n,
		.spans     (dec_spans),
		.dlens     (dec_dlens),
		.lit_marks (dec_lit),
		.slice     (dec_slice),
		.valid     (dec_valid),
		.first     (dec_first),
		.token_pos (chn_pos),
		.start_lit (chn_start_lit),
		.dlens_q   (chn_dlens),
		.slice_q   (chn_slice),
		.valid_q   (chn_valid),
		.first_q   (chn_first)
	);

	length_accum_stage u_accum (
		.clk, .rst_n,
		.token_pos   (chn_pos),
		.start_lit   (chn_start_lit),
		.dlens       (chn_dlens),
		.slice       (chn_slice),
		.valid       (chn_valid),
		.first       (chn_first),
		.slice_data  (slice_data),
		.token_pos_q (token_pos),
		.start_lit_q (start_lit),
		.address     (address),
		.slice_valid (slice_valid)
	);

endmodule

`default_nettype wire

// File: logic/tag_decoder.sv
/* speculative decode, the byte is assumed to be a tag
   kind 11 (four-byte offset copy) is reported as a one-byte token */
`timescale 1ns/1ps
`default_nettype none

module tag_decoder import preparser_pkg::*; (
	input  wire logic [23:0] tag_bytes,    // tag, then the two bytes after it
	output span_t            span,
	output dlen_t            dlen,
	output logic             is_lit
);

	tag_byte_u  tag;
	logic [7:0] ext_lo;   // first extra length byte
	logic [7:0] ext_hi;   // second, little endian

	assign tag    = tag_byte_u'(tag_bytes[23:16]);
	assign ext_lo = tag_bytes[15:8];
	assign ext_hi = tag_bytes[7:0];

	always_comb begin
		span   = span_t'(1);
		dlen   = '0;
		is_lit = 1'b0;
		if (tag_bytes[23:16] == lit_ext1_tag) begin
			// literal length lives in the next byte
			dlen   = dlen_t'(ext_lo) + dlen_t'(1);
			span   = span_t'(dlen) + span_t'(2);
			is_lit = 1'b1;
		end else if (tag_bytes[23:16] == lit_ext2_tag) begin
			dlen   = dlen_t'({ext_hi, ext_lo}) + dlen_t'(1);  // max 65536
			span   = span_t'(dlen) + span_t'(3);
			is_lit = 1'b1;
		end else begin
			case (tag.lit.kind)
				kind_literal: begin
					dlen   = dlen_t'(tag.lit.len) + dlen_t'(1);
					span   = span_t'(tag.lit.len) + span_t'(2);  // tag plus data
					is_lit = 1'b1;
				end
				kind_copy1: begin
					dlen = dlen_t'(tag.copy.len) + dlen_t'(4);
					span = span_t'(2);                            // tag, offset low
				end
				kind_copy2: begin
					// copy2 keeps its length in the literal field position
					dlen = dlen_t'(tag.lit.len) + dlen_t'(1);
					span = span_t'(3);                            // tag, two offset bytes
				end
				default: begin
					dlen = '0;                                    // never produced
					span = span_t'(1);
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/token_chain_stage.sv
/* one cycle, follows the speculative spans from the carried skip count
   skip state is ignored on the first slice of a stream */
`timescale 1ns/1ps
`default_nettype none

module token_chain_stage import preparser_pkg::*; (
	input  wire logic      clk,
	input  wire logic      rst_n,
	input  wire span_arr_t spans,
	input  wire dlen_arr_t dlens,
	input  wire pos_mask_t lit_marks,
	input  wire slice_t    slice,
	input  wire logic      valid,
	input  wire logic      first,
	output pos_mask_t      token_pos,
	output logic           start_lit,
	output dlen_arr_t      dlens_q,
	output slice_t         slice_q,
	output logic           valid_q,
	output logic           first_q
);

	span_t skip;          // stream bytes still owed by the last token
	logic  skip_lit;      // that token is a literal

	span_t                  eff_skip;
	logic                   eff_lit;
	logic [0:beat_bytes-1]  starts;     // index is byte, left bit is byte 0
	span_t                  last_end;   // end of last started token
	logic                   last_lit;
	span_t                  carry;

	assign eff_skip = first ? '0 : skip;
	assign eff_lit  = first ? 1'b0 : skip_lit;

	//////////////////////////////
	// start chain
	always_comb begin
		span_t end_pos;
		starts   = '0;
		end_pos  = '0;
		last_end = eff_skip;       // no start leaves the old skip
		last_lit = eff_lit;
		if (eff_skip < span_t'(beat_bytes))
			starts[eff_skip[3:0]] = 1'b1;
		// each start enables the byte right after its span
		for (int i = 0; i < beat_bytes; i++) begin
			if (starts[i]) begin
				end_pos  = span_t'(i) + spans[i];
				last_end = end_pos;
				last_lit = lit_marks[beat_bytes-1-i];
				if (end_pos < span_t'(beat_bytes))
					starts[end_pos[3:0]] = 1'b1;
			end
		end
		carry = last_end - span_t'(beat_bytes);   // last start always ends past byte 15
	end

	always_ff @(posedge clk) begin
		token_pos <= starts;                        // byte 0 lands on bit 15
		start_lit <= eff_lit && (eff_skip != '0);   // byte 0 is literal data
		dlens_q   <= dlens;
		slice_q   <= slice;
		if (!rst_n) begin
			skip     <= '0;
			skip_lit <= 1'b0;
			valid_q  <= 1'b0;
			first_q  <= 1'b0;
		end else begin
			valid_q <= valid;
			first_q <= first;
			if (valid) begin
				skip     <= carry;
				skip_lit <= last_lit;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/token_decode_stage.sv
/* one cycle, every byte position decoded as if a tag started there
   results are only meaningful where the chain stage later finds a start */
`timescale 1ns/1ps
`default_nettype none

module token_decode_stage import preparser_pkg::*; (
	input  wire logic   clk,
	input  wire logic   rst_n,
	input  wire slice_t slice,
	input  wire logic   slice_valid,
	input  wire logic   slice_first,
	output span_arr_t   spans,
	output dlen_arr_t   dlens,
	output pos_mask_t   lit_marks,
	output slice_t      slice_q,
	output logic        valid_q,
	output logic        first_q
);

	span_arr_t span_w;
	dlen_arr_t dlen_w;
	pos_mask_t lit_w;     // bit 15 is byte 0

	// byte j sees bytes j..j+2, the last two reach into the lookahead
	for (genvar j = 0; j < beat_bytes; j++) begin : g_dec
		tag_decoder u_dec (
			.tag_bytes (slice[slice_bytes*8-1-8*j -: 24]),
			.span      (span_w[j]),
			.dlen      (dlen_w[j]),
			.is_lit    (lit_w[beat_bytes-1-j])
		);
	end

	always_ff @(posedge clk) begin
		spans     <= span_w;       // payload, follows valid_q
		dlens     <= dlen_w;
		lit_marks <= lit_w;
		slice_q   <= slice;
		if (!rst_n) begin
			valid_q <= 1'b0;
			first_q <= 1'b0;
		end else begin
			valid_q <= slice_valid;
			first_q <= slice_first;
		end
	end

endmodule

`default_nettype wire

// File: test/clock_gen.sv
/* free running clock for the testbench, 40 ns period, starts low */
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
	output logic clk
);

	localparam realtime half_period = 20ns;   // 25 MHz

	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

endmodule

`default_nettype wire

// File: test/preparser_assert.sv
/* port checks on the pre-parser, attached with bind
   fail_cnt lets the testbench see that an assertion fired */
`timescale 1ns/1ps
`default_nettype none

module preparser_assert import preparser_pkg::*; (
	input wire logic      clk,
	input wire logic      rst_n,
	input wire logic      beat_valid,
	input wire logic      beat_last,
	input wire logic      slice_valid,
	input wire logic      start_lit,
	input wire pos_mask_t token_pos
);

	int unsigned fail_cnt = 0;   // polled by the testbench monitor

	// builder flushes in the cycle after a last beat
	a_idle_after_last: assert property (@(posedge clk) disable iff (!rst_n)
		beat_valid && beat_last |=> !beat_valid)
		else begin
			fail_cnt++;
			$error("beat_valid high in the cycle after beat_last");
		end

	// no slice may leave while reset is held
	a_quiet_in_reset: assert property (@(posedge clk)
		!rst_n && $past(!rst_n) |-> !slice_valid)
		else begin
			fail_cnt++;
			$error("slice_valid high during reset");
		end

	// byte 0 is either a tag or inside a literal, never both
	a_start_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		slice_valid |-> !(start_lit && token_pos[beat_bytes-1]))
		else begin
			fail_cnt++;
			$error("start_lit and token_pos bit 15 both high");
		end

endmodule

`default_nettype wire

// File: test/preparser_tb.sv
/* random snappy streams from a fixed seed, each slice checked against a model
   streams are whole beats, every one closed by a literal that fills the last beat */
`timescale 1ns/1ps
`default_nettype none

module preparser_tb import preparser_pkg::*; ();

	localparam int num_streams = 40;
	localparam int rand_seed   = 43612;

	logic      clk;
	logic      rst_n;
	beat_t     beat_data;
	logic      beat_valid;
	logic      beat_last;
	slice_t    slice_data;
	pos_mask_t token_pos;
	logic      start_lit;
	addr_t     address;
	logic      slice_valid;

	// stream under construction and its token list
	logic [7:0]  sbytes [$];
	int unsigned tok_span [$];
	int unsigned tok_dlen [$];
	bit          tok_lit [$];

	// expected slices, oldest first
	slice_t    exp_data [$];
	pos_mask_t exp_pos [$];
	logic      exp_lit [$];
	addr_t     exp_addr [$];

	int stream_beats [num_streams];
	int total_beats;
	int slices_seen;

	clock_gen u_clk (.clk(clk));

	snappy_preparser uut (
		.clk, .rst_n, .beat_data, .beat_valid, .beat_last,
		.slice_data, .token_pos, .start_lit, .address, .slice_valid
	);

	bind snappy_preparser preparser_assert u_props (
		.clk(clk), .rst_n(rst_n), .beat_valid(beat_valid), .beat_last(beat_last),
		.slice_valid(slice_valid), .start_lit(start_lit), .token_pos(token_pos)
	);

	//////////////////////////////
	// token writers
	// enc 0 short tag, 1 one length byte (F0h), 2 two length bytes (F4h)
	task automatic literal_token(int unsigned len, int enc);
		logic [15:0] lm1;
		lm1 = 16'(len - 1);
		if (enc == 0) begin
			sbytes.push_back({lm1[5:0], kind_literal});
		end else if (enc == 1) begin
			sbytes.push_back(lit_ext1_tag);
			sbytes.push_back(lm1[7:0]);
		end else begin
			sbytes.push_back(lit_ext2_tag);
			sbytes.push_back(lm1[7:0]);     // little endian
			sbytes.push_back(lm1[15:8]);
		end
		repeat (len) sbytes.push_back(8'($urandom));
		tok_span.push_back(len + 1 + enc);
		tok_dlen.push_back(len);
		tok_lit.push_back(1'b1);
	endtask

	task automatic copy1_token();
		logic [2:0] len_f;
		len_f = 3'($urandom);
		sbytes.push_back({3'($urandom), len_f, kind_copy1});
		sbytes.push_back(8'($urandom));     // offset low byte
		tok_span.push_back(2);
		tok_dlen.push_back(len_f + 4);
		tok_lit.push_back(1'b0);
	endtask

	task automatic copy2_token();
		logic [5:0] len_f;
		len_f = 6'($urandom);
		sbytes.push_back({len_f, kind_copy2});
		sbytes.push_back(8'($urandom));
		sbytes.push_back(8'($urandom));
		tok_span.push_back(3);
		tok_dlen.push_back(len_f + 1);
		tok_lit.push_back(1'b0);
	endtask

	// random tokens, never leaving a single byte, closed by a filling literal
	task automatic build_stream(int nb);
		int unsigned rem;
		int unsigned len;
		int          pick;
		int          enc;
		bit          done;
		sbytes.delete();
		tok_span.delete();
		tok_dlen.delete();
		tok_lit.delete();
		done = 1'b0;
		while (!done) begin
			rem = nb * beat_bytes - sbytes.size();
			if (rem <= 20 || $urandom_range(0, 9) == 0) begin
				if (rem <= 61)
					literal_token(rem - 1, 0);
				else
					literal_token(rem - 2, 1);
				done = 1'b1;
			end else begin
				pick = $urandom_range(0, 3);
				len  = $urandom_range(1, 60);
				enc  = 0;
				if (pick == 1) begin
					len = $urandom_range(1, 300);
					enc = (len > 256) ? 2 : $urandom_range(1, 2);
				end
				if (pick == 2)
					copy1_token();
				else if (pick == 3)
					copy2_token();
				else if (len + 1 + enc + 2 <= rem)   // two bytes left for the closer
					literal_token(len, enc);
			end
		end
	endtask

	//////////////////////////////
	// reference model, walks the token list
	task automatic model_stream(int nb);
		int          total;
		int          pos;
		int          b;
		bit          tag_at [];
		bit          lit_at [];
		int unsigned dlen_at [];
		addr_t       acc;
		slice_t      d;
		pos_mask_t   p;
		total   = nb * beat_bytes;
		tag_at  = new[total];
		lit_at  = new[total];
		dlen_at = new[total];
		pos     = 0;
		foreach (tok_span[t]) begin
			tag_at[pos]  = 1'b1;
			dlen_at[pos] = tok_dlen[t];
			for (int i = 0; i < tok_span[t]; i++)
				lit_at[pos + i] = tok_lit[t];    // every byte of the token
			pos += tok_span[t];
		end
		acc = '0;
		for (int k = 0; k < nb; k++) begin
			d = '0;
			p = '0;
			for (int j = 0; j < slice_bytes; j++) begin
				b = beat_bytes * k + j;
				d = {d[slice_bytes*8-9:0], (b < total) ? sbytes[b] : 8'h00};
			end
			for (int j = 0; j < beat_bytes; j++)
				p[beat_bytes-1-j] = tag_at[beat_bytes*k + j];
			exp_data.push_back(d);
			exp_pos.push_back(p);
			exp_lit.push_back(!tag_at[beat_bytes*k] && lit_at[beat_bytes*k]);
			exp_addr.push_back(acc);            // earlier slices only
			for (int j = 0; j < beat_bytes; j++)
				if (tag_at[beat_bytes*k + j])
					acc += addr_t'(dlen_at[beat_bytes*k + j]);
		end
	endtask

	task automatic compare(string name, logic [slice_bytes*8-1:0] got,
		logic [slice_bytes*8-1:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s slice %0d got %0h expected %0h",
				name, slices_seen, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic watchdog();
		longint limit_ns;
		limit_ns = longint'(total_beats) * 40 * 3 + 2000;
		#(limit_ns);
		$display("timeout: no verdict after %0d ns, the run hung", limit_ns);
		$display("CHECKS FAILED");
		$fatal(1, "watchdog expired");
	endtask

	//////////////////////////////
	// output monitor, samples away from the rising edge
	always @(negedge clk) begin
		if (uut.u_props.fail_cnt != 0) begin
			$display("an assertion on the DUT ports failed, see the error above");
			$display("CHECKS FAILED");
			$fatal(1, "assertion failure");
		end else if (rst_n && slice_valid) begin
			if (exp_addr.size() == 0) begin
				$display("slice_valid came while no slice was expected");
				$display("CHECKS FAILED");
				$fatal(1, "unexpected slice");
			end else begin
				compare("slice_data", slice_data, exp_data.pop_front());
				compare("token_pos", token_pos, exp_pos.pop_front());
				compare("start_lit", start_lit, exp_lit.pop_front());
				compare("address", address, exp_addr.pop_front());
				slices_seen++;
			end
		end
	end

	initial begin : stimulus
		beat_t bd;
		int    nb;
		rst_n       = 1'b0;
		beat_data   = '0;
		beat_valid  = 1'b0;
		beat_last   = 1'b0;
		slices_seen = 0;
		total_beats = 0;
		void'($urandom(rand_seed));
		foreach (stream_beats[s]) begin
			// two one-beat streams back to back, the rest random
			stream_beats[s] = (s == 3 || s == 4) ? 1 : $urandom_range(1, 12);
			total_beats += stream_beats[s];
		end
		fork
			watchdog();
		join_none
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		for (int s = 0; s < num_streams; s++) begin
			nb = stream_beats[s];
			build_stream(nb);
			model_stream(nb);
			for (int b = 0; b < nb; b++) begin
				if ($urandom_range(0, 3) == 0) begin
					@(posedge clk);               // gap, data must be ignored
					beat_data  <= beat_t'({$urandom, $urandom, $urandom, $urandom});
					beat_valid <= 1'b0;
					beat_last  <= 1'b0;
				end
				for (int i = 0; i < beat_bytes; i++)
					bd = {bd[beat_bytes*8-9:0], sbytes[beat_bytes*b + i]};
				@(posedge clk);
				beat_data  <= bd;
				beat_valid <= 1'b1;
				beat_last  <= (b == nb - 1);
			end
			@(posedge clk);                       // idle cycle for the flush
			beat_valid <= 1'b0;
			beat_last  <= 1'b0;
		end
		repeat (8) @(posedge clk);                // pipeline drain
		if (exp_addr.size() != 0) begin
			$display("%0d expected slices never came out", exp_addr.size());
			$display("CHECKS FAILED");
			$fatal(1, "missing slices");
		end else begin
			$display("%0d slices from %0d beats checked", slices_seen, total_beats);
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire
